// ==== common/membus_pkg.sv ====
/*
 * Address map, latency and in-flight limits of the memory bus.
 * Region bounds are inclusive byte addresses and both regions are size aligned.
 * bus_latency must be at least 2 because the memories read one stage early.
 */
`default_nettype none

package membus_pkg;

    // Pipeline and credits
    localparam int bus_latency = 5;      // Edges from acceptance to completion
    localparam int max_reads   = 2;
    localparam int max_writes  = 1;
    localparam int count_width = 8;

    // Address map
    localparam logic [31:0] text_begin = 32'h0040_0000;
    localparam logic [31:0] text_end   = 32'h0040_007F;
    localparam logic [31:0] data_begin = 32'h1001_0000;
    localparam logic [31:0] data_end   = 32'h1001_00FF;

    // Memory sizes in words, as index widths
    localparam int text_words_log2 = 5;
    localparam int data_words_log2 = 6;

    localparam string text_image_file = "tb/text_image.hex";

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] write_data;
        logic [3:0]  byte_enable;
        logic        read_enable;
        logic        write_enable;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== common/mem_req_if.sv ====
/*
 * One stage of the request delay line.
 * stage_valid is high when the stage holds an accepted read or write.
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if
    import membus_pkg::*;
();

    mem_req_t req;
    logic     stage_valid;

    modport source (
        output req,
        output stage_valid
    );

    modport sink (
        input req,
        input stage_valid
    );

endinterface

`default_nettype wire

// ==== hw/membus/membus_credit_counter.sv ====
/*
 * Tracks accepted but unretired reads and writes.
 * A request that both reads and writes takes one credit of each kind.
 * The master must hold a request while wait_req is high.
 */
`timescale 1ns/1ps
`default_nettype none

module membus_credit_counter
    import membus_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic read_enable,
    input  wire logic write_enable,
    input  wire logic read_retire,
    input  wire logic write_retire,
    output logic      wait_req,
    output logic      read_accept,
    output logic      write_accept
);

    logic [count_width-1:0] reads_in_flight;
    logic [count_width-1:0] writes_in_flight;
    logic                   reads_full;
    logic                   writes_full;

    // A retiring request frees its credit in the same cycle
    assign reads_full  = reads_in_flight >= count_width'(max_reads) && !read_retire;
    assign writes_full = writes_in_flight >= count_width'(max_writes) && !write_retire;

    assign wait_req     = reads_full || writes_full;
    assign read_accept  = read_enable && !wait_req;
    assign write_accept = write_enable && !wait_req;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            reads_in_flight  <= '0;
            writes_in_flight <= '0;
        end else begin
            reads_in_flight  <= reads_in_flight
                              + count_width'(read_accept)
                              - count_width'(read_retire);
            writes_in_flight <= writes_in_flight
                              + count_width'(write_accept)
                              - count_width'(write_retire);
        end
    end

endmodule

`default_nettype wire

// ==== hw/membus/membus_delay_line.sv ====
/*
 * Fixed-depth request pipeline, one stage per clock, no stalls.
 * Stage 1 enables come from the accept strobes, not from the request itself.
 * depth must be at least 2.
 */
`timescale 1ns/1ps
`default_nettype none

module membus_delay_line
    import membus_pkg::*;
#(
    parameter int depth = bus_latency
) (
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire mem_req_t request,
    input  wire logic     read_accept,
    input  wire logic     write_accept,
    mem_req_if.source     tap_read,
    mem_req_if.source     tap_done
);

    logic [31:0]    address_q     [1:depth];
    logic [31:0]    write_data_q  [1:depth];
    logic [3:0]     byte_enable_q [1:depth];
    logic [depth:1] read_q;
    logic [depth:1] write_q;

    always_ff @(posedge clock) begin
        address_q[1]     <= request.address;
        write_data_q[1]  <= request.write_data;
        byte_enable_q[1] <= request.byte_enable;
        for (int i = 2; i <= depth; i++) begin
            address_q[i]     <= address_q[i-1];
            write_data_q[i]  <= write_data_q[i-1];
            byte_enable_q[i] <= byte_enable_q[i-1];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            read_q  <= '0;
            write_q <= '0;
        end else begin
            read_q  <= {read_q[depth-1:1], read_accept};
            write_q <= {write_q[depth-1:1], write_accept};
        end
    end

    // Stage depth-1 addresses the memories one edge before completion
    assign tap_read.req = '{address:      address_q[depth-1],
                            write_data:   write_data_q[depth-1],
                            byte_enable:  byte_enable_q[depth-1],
                            read_enable:  read_q[depth-1],
                            write_enable: write_q[depth-1]};
    assign tap_read.stage_valid = read_q[depth-1] || write_q[depth-1];

    assign tap_done.req = '{address:      address_q[depth],
                            write_data:   write_data_q[depth],
                            byte_enable:  byte_enable_q[depth],
                            read_enable:  read_q[depth],
                            write_enable: write_q[depth]};
    assign tap_done.stage_valid = read_q[depth] || write_q[depth];

endmodule

`default_nettype wire

// ==== hw/memory/text_rom.sv ====
/*
 * Word ROM with a registered read port.
 * Contents come from text_image_file at elaboration and never change.
 */
`timescale 1ns/1ps
`default_nettype none

module text_rom
    import membus_pkg::*;
(
    input  wire logic                       clock,
    input  wire logic [text_words_log2-1:0] index,
    output logic [31:0]                     word
);

    logic [31:0] rom [2**text_words_log2];

    initial begin
        $readmemh(text_image_file, rom);
    end

    always_ff @(posedge clock) begin
        word <= rom[index];
    end

endmodule

`default_nettype wire

// ==== hw/memory/data_ram.sv ====
/*
 * Word RAM with a registered read port and byte-lane writes.
 * A read and a write to the same word at one edge return the new bytes.
 */
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import membus_pkg::*;
(
    input  wire logic                       clock,
    input  wire logic [data_words_log2-1:0] read_index,
    input  wire logic [data_words_log2-1:0] write_index,
    input  wire logic [31:0]                write_data,
    input  wire logic [3:0]                 byte_enable,
    input  wire logic                       write,
    output logic [31:0]                     word
);

    logic [31:0] ram [2**data_words_log2];
    logic [31:0] read_next;

    // Forward lanes written at this edge to the read port
    always_comb begin
        read_next = ram[read_index];
        for (int lane = 0; lane < 4; lane++) begin
            if (write && byte_enable[lane] && write_index == read_index) begin
                read_next[8*lane +: 8] = write_data[8*lane +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (write && byte_enable[lane]) begin
                ram[write_index][8*lane +: 8] <= write_data[8*lane +: 8];
            end
        end
        word <= read_next;
    end

endmodule

`default_nettype wire

// ==== hw/membus/membus_top.sv ====
/*
 * Memory bus in front of the text ROM and the data RAM.
 * Fixed latency of bus_latency edges, in-order completion, word accesses only.
 * Unmapped accesses and text writes complete with bus_error and change nothing.
 */
`timescale 1ns/1ps
`default_nettype none

module membus_top
    import membus_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic [31:0] address,
    input  wire logic [31:0] write_data,
    input  wire logic [3:0]  byte_enable,
    input  wire logic        read_enable,
    input  wire logic        write_enable,
    output logic [31:0]      read_data,
    output logic             wait_req,
    output logic             valid,
    output logic             bus_error
);

    mem_req_t    request;
    logic        read_accept;
    logic        write_accept;
    logic        read_retire;
    logic        write_retire;
    logic        done_text_hit;
    logic        done_data_hit;
    logic        ram_write;
    logic [31:0] text_word;
    logic [31:0] data_word;

    mem_req_if tap_read ();
    mem_req_if tap_done ();

    function automatic logic in_region(logic [31:0] addr, logic [31:0] lo, logic [31:0] hi);
        return addr >= lo && addr <= hi;
    endfunction

    assign request = '{address:      address,
                       write_data:   write_data,
                       byte_enable:  byte_enable,
                       read_enable:  read_enable,
                       write_enable: write_enable};

    membus_credit_counter credits (
        .clock        (clock),
        .reset        (reset),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .read_retire  (read_retire),
        .write_retire (write_retire),
        .wait_req     (wait_req),
        .read_accept  (read_accept),
        .write_accept (write_accept)
    );

    membus_delay_line #(.depth(bus_latency)) pipeline (
        .clock        (clock),
        .reset        (reset),
        .request      (request),
        .read_accept  (read_accept),
        .write_accept (write_accept),
        .tap_read     (tap_read),
        .tap_done     (tap_done)
    );

    text_rom text_memory (
        .clock (clock),
        .index (tap_read.req.address[text_words_log2+1:2]),
        .word  (text_word)
    );

    data_ram data_memory (
        .clock       (clock),
        .read_index  (tap_read.req.address[data_words_log2+1:2]),
        .write_index (tap_done.req.address[data_words_log2+1:2]),
        .write_data  (tap_done.req.write_data),
        .byte_enable (tap_done.req.byte_enable),
        .write       (ram_write),
        .word        (data_word)
    );

    assign done_text_hit = in_region(tap_done.req.address, text_begin, text_end);
    assign done_data_hit = in_region(tap_done.req.address, data_begin, data_end);
    assign ram_write     = tap_done.req.write_enable && done_data_hit;

    always_comb begin
        if (!tap_done.req.read_enable) read_data = '0;
        else if (done_text_hit)        read_data = text_word;
        else if (done_data_hit)        read_data = data_word;
        else                           read_data = '0;  // Unmapped read
    end

    assign valid     = tap_done.req.read_enable;
    assign bus_error = tap_done.stage_valid
                    && (!(done_text_hit || done_data_hit)
                        || (done_text_hit && tap_done.req.write_enable));

    assign read_retire  = tap_done.req.read_enable;
    assign write_retire = tap_done.req.write_enable;

endmodule

`default_nettype wire

// ==== tb/membus_tb.sv ====
/*
 * Random test of the memory bus against a cycle model of both memories and the credits.
 * Requests are held while wait_req is high, and the RAM is filled before random traffic.
 * Outputs are sampled mid-cycle and the text image is read from tb/text_image.hex.
 */
`timescale 1ns/1ps
`default_nettype none

module membus_tb
    import membus_pkg::*;
();

    localparam int clock_period = 40;
    localparam int drive_delay  = 2;
    localparam int text_words   = 2**text_words_log2;
    localparam int data_words   = 2**data_words_log2;
    localparam int random_count = 400;
    localparam int num_requests = data_words + 4 + random_count;

    logic        clock;
    logic        reset;
    logic [31:0] address;
    logic [31:0] write_data;
    logic [3:0]  byte_enable;
    logic        read_enable;
    logic        write_enable;
    logic [31:0] read_data;
    logic        wait_req;
    logic        valid;
    logic        bus_error;

    logic [31:0] text_model [text_words];
    logic [31:0] data_model [data_words];
    mem_req_t    pending_q  [$];       // Accepted but not yet completed
    int          due_q      [$];       // Completion cycle of each pending request
    int          cycle;
    integer      seed = 32'h6b16_f7bf;

    membus_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .address      (address),
        .write_data   (write_data),
        .byte_enable  (byte_enable),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .read_data    (read_data),
        .wait_req     (wait_req),
        .valid        (valid),
        .bus_error    (bus_error)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period/2) clock = ~clock;
    end

    initial begin
        #((num_requests + 10) * bus_latency * clock_period * 4);
        $display("Timeout: the bus stopped completing requests");
        $display("Test failures found");
        $fatal(1);
    end

    function automatic logic in_text(logic [31:0] addr);
        return addr >= text_begin && addr <= text_end;
    endfunction

    function automatic logic in_data(logic [31:0] addr);
        return addr >= data_begin && addr <= data_end;
    endfunction

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old_word, logic [31:0] new_word,
                                                logic [3:0] lanes);
        logic [31:0] result;
        result = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) result[8*lane +: 8] = new_word[8*lane +: 8];
        end
        return result;
    endfunction

    function automatic mem_req_t make_request(logic [31:0] addr, logic [31:0] data,
                                              logic [3:0] lanes, logic rd, logic wr);
        return '{address: addr, write_data: data, byte_enable: lanes,
                 read_enable: rd, write_enable: wr};
    endfunction

    // Mostly mapped words with a tenth unmapped
    function automatic logic [31:0] random_address();
        int pick;
        pick = {$random(seed)} % 10;
        if (pick < 4) return text_begin + ({$random(seed)} % text_words) * 4;
        if (pick < 9) return data_begin + ({$random(seed)} % data_words) * 4;
        if ($random(seed) & 1) return text_end + 1 + ({$random(seed)} % 32) * 4;
        return 32'h2000_0000 | ({$random(seed)} & 32'h0FFF_FFFC);
    endfunction

    function automatic logic predict_wait(logic retiring);
        int reads;
        int writes;
        logic read_retires;
        logic write_retires;
        reads  = 0;
        writes = 0;
        foreach (pending_q[i]) begin
            reads  += pending_q[i].read_enable;
            writes += pending_q[i].write_enable;
        end
        read_retires  = retiring && pending_q[0].read_enable;
        write_retires = retiring && pending_q[0].write_enable;
        return (reads >= max_reads && !read_retires) || (writes >= max_writes && !write_retires);
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s: got %h, expected %h in cycle %0d", name, got, expected, cycle);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERR %s: got %h, expected %h in cycle %0d", name, got, expected, cycle);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // Drives one clock cycle, checks the outputs and advances the model
    task automatic run_cycle(input mem_req_t req, output logic accepted);
        logic        retiring;
        logic        expect_wait;
        logic        text_hit;
        logic        data_hit;
        logic [31:0] expect_data;
        mem_req_t    retired;
        @(posedge clock);
        cycle++;
        #drive_delay;
        address      = req.address;
        write_data   = req.write_data;
        byte_enable  = req.byte_enable;
        read_enable  = req.read_enable;
        write_enable = req.write_enable;
        #(clock_period/2 - drive_delay);
        retiring    = due_q.size() > 0 && due_q[0] == cycle;
        expect_wait = predict_wait(retiring);
        check_flag("wait_req", wait_req, expect_wait);
        if (retiring) begin
            retired     = pending_q.pop_front();
            void'(due_q.pop_front());
            text_hit    = in_text(retired.address);
            data_hit    = in_data(retired.address);
            expect_data = '0;
            if (text_hit) expect_data = text_model[(retired.address - text_begin) >> 2];
            else if (data_hit) expect_data = data_model[(retired.address - data_begin) >> 2];
            check_flag("valid", valid, retired.read_enable);
            check_flag("bus_error", bus_error,
                       !(text_hit || data_hit) || (text_hit && retired.write_enable));
            if (retired.read_enable) check_word("read_data", read_data, expect_data);
            if (retired.write_enable && data_hit) begin   // Old word already returned
                data_model[(retired.address - data_begin) >> 2] =
                    merge_bytes(expect_data, retired.write_data, retired.byte_enable);
            end
        end else begin
            check_flag("valid", valid, 1'b0);
            check_flag("bus_error", bus_error, 1'b0);
        end
        accepted = (req.read_enable || req.write_enable) && !expect_wait;
        if (accepted) begin
            pending_q.push_back(req);
            due_q.push_back(cycle + bus_latency);
        end
    endtask

    // Holds the request until the bus takes it
    task automatic issue(input mem_req_t req);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) run_cycle(req, accepted);
    endtask

    initial begin
        logic [31:0] target;
        logic [31:0] data;
        logic [3:0]  lanes;
        logic        accepted;
        int          op;
        reset        = 1'b1;
        address      = '0;
        write_data   = '0;
        byte_enable  = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        cycle        = 0;
        $readmemh(text_image_file, text_model);
        repeat (3) @(posedge clock);
        #drive_delay;
        reset = 1'b0;

        for (int i = 0; i < data_words; i++) begin
            target = data_begin + i * 4;
            issue(make_request(target, fill_word(target), 4'hF, 1'b0, 1'b1));
        end

        target = data_begin + 32'h24;
        issue(make_request(target, 32'hdead_beef, 4'b0101, 1'b0, 1'b1));
        issue(make_request(target, '0, '0, 1'b1, 1'b0));
        issue(make_request(target, 32'h1234_5678, 4'hF, 1'b1, 1'b1));   // Returns old word
        issue(make_request(text_begin + 32'h10, 32'hffff_ffff, 4'hF, 1'b1, 1'b1));

        for (int n = 0; n < random_count; n++) begin
            op     = {$random(seed)} % 10;
            target = random_address();
            data   = $random(seed);
            lanes  = $random(seed);
            if (op < 2) run_cycle(make_request('0, '0, '0, 1'b0, 1'b0), accepted);
            else if (op < 6) issue(make_request(target, data, lanes, 1'b1, 1'b0));
            else if (op < 9) issue(make_request(target, data, lanes, 1'b0, 1'b1));
            else issue(make_request(target, data, lanes, 1'b1, 1'b1));
        end

        repeat (bus_latency + 2) run_cycle(make_request('0, '0, '0, 1'b0, 1'b0), accepted);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/text_image.hex ====
// One 32-bit RISC-V instruction word per line, text word 0 first
10010537
00052283
00452303
006283b3
00752423
00100e13
01c383b3
00000013
fe0e1ee3
00a00893
00000073
00128293
40628333
0062f3b3
0062e433
0062c4b3
00229513
0022d593
4022d613
00c0006f
00000013
00000013
fff00693
00d52623
00c52703
00e68463
0040006f
00008067
ff010113
00112623
00c12083
01010113

// ==== vlog.f ====
common/membus_pkg.sv
common/mem_req_if.sv
hw/membus/membus_credit_counter.sv
hw/membus/membus_delay_line.sv
hw/memory/text_rom.sv
hw/memory/data_ram.sv
hw/membus/membus_top.sv
tb/membus_tb.sv

// ==== Bender.yml ====
package:
  name: membus

sources:
  - common/membus_pkg.sv
  - common/mem_req_if.sv
  - hw/membus/membus_credit_counter.sv
  - hw/membus/membus_delay_line.sv
  - hw/memory/text_rom.sv
  - hw/memory/data_ram.sv
  - hw/membus/membus_top.sv
  - target: test
    files:
      - tb/membus_tb.sv
